// File: source/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ==============================
// System clock
// ==============================
`define SOC_FREQUENCY 32'd100_000_000

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// ==============================
// Near bus regions, address bits 31..28
// ==============================
`define SOC_REGION_ROM 4'h0
`define SOC_REGION_RAM 4'h2
`define SOC_REGION_BRIDGE 4'h5

// Far bus devices, address bits 27..24
`define SOC_FAR_TIMER 4'h5
`define SOC_FAR_SYSREG 4'h9

// ==============================
// Memories and system registers
// ==============================
`define SOC_ROM_WORDS 256
`define SOC_RAM_WORDS 1024
`define SOC_ROM_SIGNATURE 16'hA5C3
`define SOC_DEVICE_ID 32'd1
`define SOC_LED_W 10

`endif

// File: source/soc_pkg.sv
`include "soc_params.svh"

package soc_pkg;

	// ==============================
	// Bus requests
	// ==============================

	// rw set means write
	typedef struct packed {
		logic rw;
		logic [`SOC_ADDR_W-1:0] address;
		logic [`SOC_DATA_W-1:0] wdata;
	} bus_request_t;

	// Far side sees only the low 28 address bits
	typedef struct packed {
		logic rw;
		logic [27:0] address;
		logic [`SOC_DATA_W-1:0] wdata;
	} far_request_t;

	// ==============================
	// Enumerations
	// ==============================

	// Bus owner, also reported as fault source
	typedef enum logic [1:0] {
		NONE,
		INSTRUCTION,
		DATA,
		DMA
	} bus_source_e;

	typedef enum logic [1:0] {
		ROM,
		RAM,
		BRIDGE,
		INVALID
	} bus_region_e;

	typedef enum logic [1:0] {
		IDLE,
		FAR,
		REPLY
	} bridge_state_e;

	// Word offsets, address bits 4..2
	typedef enum logic [2:0] {
		COUNTER = 3'd0,
		COMPARE = 3'd1,
		CONTROL = 3'd2
	} timer_reg_e;

	// Word offsets, address bits 3..2
	typedef enum logic [1:0] {
		DEVICE_ID = 2'd0,
		FREQUENCY = 2'd1,
		LEDS = 2'd2
	} sysreg_reg_e;

endpackage

// File: source/system_bus.sv
`include "soc_params.svh"

module system_bus(
	input i_clock,
	input i_reset,

	// Instruction port, read only
	input i_ibus_valid,
	input [`SOC_ADDR_W-1:0] i_ibus_address,
	output logic o_ibus_ready,
	output logic [`SOC_DATA_W-1:0] o_ibus_rdata,

	// Data port
	input i_dbus_valid,
	input soc_pkg::bus_request_t i_dbus_request,
	output logic o_dbus_ready,
	output logic [`SOC_DATA_W-1:0] o_dbus_rdata,

	// DMA port
	input i_dma_valid,
	input soc_pkg::bus_request_t i_dma_request,
	output logic o_dma_ready,
	output logic [`SOC_DATA_W-1:0] o_dma_rdata,

	// Targets
	output logic o_rom_valid,
	output logic o_ram_valid,
	output logic o_bridge_valid,
	output soc_pkg::bus_request_t o_target_request,
	input i_rom_ready,
	input [`SOC_DATA_W-1:0] i_rom_rdata,
	input i_ram_ready,
	input [`SOC_DATA_W-1:0] i_ram_rdata,
	input i_bridge_ready,
	input [`SOC_DATA_W-1:0] i_bridge_rdata,

	// Fault report
	output logic o_bus_fault,
	output logic [`SOC_ADDR_W-1:0] o_fault_address,
	output soc_pkg::bus_source_e o_fault_source
);

	soc_pkg::bus_source_e owner;
	soc_pkg::bus_source_e next_owner;
	soc_pkg::bus_region_e region;
	soc_pkg::bus_request_t ibus_request;
	logic issued;
	logic issue;
	logic done;
	logic [`SOC_DATA_W-1:0] rdata;

	assign ibus_request = '{rw: 1'b0, address: i_ibus_address, wdata: '0};

	// ==============================
	// Arbitration
	// ==============================

	// Fixed priority, instruction first
	always_comb begin
		if (i_ibus_valid)
			next_owner = soc_pkg::INSTRUCTION;
		else if (i_dbus_valid)
			next_owner = soc_pkg::DATA;
		else if (i_dma_valid)
			next_owner = soc_pkg::DMA;
		else
			next_owner = soc_pkg::NONE;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			owner <= soc_pkg::NONE;
			issued <= 1'b0;
		end else if (owner == soc_pkg::NONE) begin
			owner <= next_owner;
			issued <= 1'b0;
		end else begin
			// Target sees valid only in the first owned cycle
			issued <= 1'b1;
			if (done)
				owner <= soc_pkg::NONE;
		end
	end

	always_comb begin
		case (owner)
			soc_pkg::INSTRUCTION: o_target_request = ibus_request;
			soc_pkg::DATA: o_target_request = i_dbus_request;
			soc_pkg::DMA: o_target_request = i_dma_request;
			default: o_target_request = '0;
		endcase
	end

	// ==============================
	// Decode and response
	// ==============================

	always_comb begin
		case (o_target_request.address[31:28])
			`SOC_REGION_ROM: region = soc_pkg::ROM;
			`SOC_REGION_RAM: region = soc_pkg::RAM;
			`SOC_REGION_BRIDGE: region = soc_pkg::BRIDGE;
			default: region = soc_pkg::INVALID;
		endcase
	end

	assign issue = (owner != soc_pkg::NONE) && !issued;
	assign o_rom_valid = issue && (region == soc_pkg::ROM);
	assign o_ram_valid = issue && (region == soc_pkg::RAM);
	assign o_bridge_valid = issue && (region == soc_pkg::BRIDGE);

	// Unmapped region completes here with zero data
	assign o_bus_fault = issue && (region == soc_pkg::INVALID);
	assign o_fault_address = o_bus_fault ? o_target_request.address : '0;
	assign o_fault_source = o_bus_fault ? owner : soc_pkg::NONE;

	always_comb begin
		case (region)
			soc_pkg::ROM: begin
				done = i_rom_ready;
				rdata = i_rom_rdata;
			end
			soc_pkg::RAM: begin
				done = i_ram_ready;
				rdata = i_ram_rdata;
			end
			soc_pkg::BRIDGE: begin
				done = i_bridge_ready;
				rdata = i_bridge_rdata;
			end
			default: begin
				done = o_bus_fault;
				rdata = '0;
			end
		endcase
	end

	// Only the owner hears the reply
	assign o_ibus_ready = done && (owner == soc_pkg::INSTRUCTION);
	assign o_dbus_ready = done && (owner == soc_pkg::DATA);
	assign o_dma_ready = done && (owner == soc_pkg::DMA);
	assign o_ibus_rdata = (owner == soc_pkg::INSTRUCTION) ? rdata : '0;
	assign o_dbus_rdata = (owner == soc_pkg::DATA) ? rdata : '0;
	assign o_dma_rdata = (owner == soc_pkg::DMA) ? rdata : '0;

endmodule

// File: source/boot_rom.sv
`include "soc_params.svh"

module boot_rom(
	input i_clock,
	input i_valid,
	input [`SOC_ADDR_W-1:0] i_address,
	output logic o_ready,
	output logic [`SOC_DATA_W-1:0] o_rdata
);

	localparam int INDEX_W = $clog2(`SOC_ROM_WORDS);

	logic [INDEX_W-1:0] index;

	// Word index wraps at the ROM size
	assign index = i_address[INDEX_W+1:2];

	always_ff @(posedge i_clock) begin
		o_ready <= i_valid;
	end

	// Signature on top, word index below
	always_ff @(posedge i_clock) begin
		if (i_valid)
			o_rdata <= {`SOC_ROM_SIGNATURE, 16'(index)};
	end

endmodule

// File: source/block_ram.sv
`include "soc_params.svh"

module block_ram(
	input i_clock,
	input i_valid,
	input soc_pkg::bus_request_t i_request,
	output logic o_ready,
	output logic [`SOC_DATA_W-1:0] o_rdata
);

	localparam int INDEX_W = $clog2(`SOC_RAM_WORDS);

	logic [`SOC_DATA_W-1:0] memory [`SOC_RAM_WORDS];
	logic [INDEX_W-1:0] index;

	// Upper address bits alias
	assign index = i_request.address[INDEX_W+1:2];

	always_ff @(posedge i_clock) begin
		o_ready <= i_valid;
	end

	// Read before write, a write returns the old word
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_rdata <= memory[index];
			if (i_request.rw)
				memory[index] <= i_request.wdata;
		end
	end

endmodule

// File: source/io_bridge.sv
`include "soc_params.svh"

module io_bridge(
	input i_clock,
	input i_reset,

	// Near side
	input i_valid,
	input soc_pkg::bus_request_t i_request,
	output logic o_ready,
	output logic [`SOC_DATA_W-1:0] o_rdata,

	// Far side
	output logic o_timer_valid,
	output logic o_sysreg_valid,
	output soc_pkg::far_request_t o_far_request,
	input i_timer_ready,
	input [`SOC_DATA_W-1:0] i_timer_rdata,
	input i_sysreg_ready,
	input [`SOC_DATA_W-1:0] i_sysreg_rdata
);

	soc_pkg::bridge_state_e state;
	logic far_valid;
	logic timer_select;
	logic sysreg_select;
	logic far_ready;
	logic [`SOC_DATA_W-1:0] far_rdata;
	logic far_done;

	// ==============================
	// Far decode
	// ==============================
	assign timer_select = o_far_request.address[27:24] == `SOC_FAR_TIMER;
	assign sysreg_select = o_far_request.address[27:24] == `SOC_FAR_SYSREG;

	assign o_timer_valid = far_valid && timer_select;
	assign o_sysreg_valid = far_valid && sysreg_select;

	assign far_ready = (timer_select && i_timer_ready) || (sysreg_select && i_sysreg_ready);
	assign far_rdata = timer_select ? i_timer_rdata :
		sysreg_select ? i_sysreg_rdata :
		'0;

	// Unused device answers after the same delay, with zero data
	assign far_done = !far_valid && (far_ready || !(timer_select || sysreg_select));

	// ==============================
	// Bridge FSM
	// ==============================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= soc_pkg::IDLE;
			far_valid <= 1'b0;
		end else begin
			case (state)
				soc_pkg::IDLE: begin
					if (i_valid) begin
						state <= soc_pkg::FAR;
						far_valid <= 1'b1;
					end
				end
				soc_pkg::FAR: begin
					far_valid <= 1'b0;
					if (far_done)
						state <= soc_pkg::REPLY;
				end
				default: state <= soc_pkg::IDLE;
			endcase
		end
	end

	// Request and reply payload
	always_ff @(posedge i_clock) begin
		if (state == soc_pkg::IDLE && i_valid)
			o_far_request <= '{
				rw: i_request.rw,
				address: i_request.address[27:0],
				wdata: i_request.wdata
			};
		if (state == soc_pkg::FAR && far_done)
			o_rdata <= far_rdata;
	end

	assign o_ready = state == soc_pkg::REPLY;

endmodule

// File: source/system_timer.sv
`include "soc_params.svh"

module system_timer(
	input i_clock,
	input i_reset,
	input i_valid,
	input soc_pkg::far_request_t i_request,
	output logic o_ready,
	output logic [`SOC_DATA_W-1:0] o_rdata,
	output logic o_interrupt
);

	soc_pkg::timer_reg_e select;
	logic [`SOC_DATA_W-1:0] counter;
	logic [`SOC_DATA_W-1:0] compare;
	logic [`SOC_DATA_W-1:0] control;
	logic [`SOC_DATA_W-1:0] read_data;

	assign select = soc_pkg::timer_reg_e'(i_request.address[4:2]);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			counter <= '0;
			compare <= '0;
			control <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= i_valid;
			// Free running while enabled
			if (control[0])
				counter <= counter + `SOC_DATA_W'(1);
			if (i_valid && i_request.rw) begin
				case (select)
					soc_pkg::COUNTER: counter <= i_request.wdata;
					soc_pkg::COMPARE: compare <= i_request.wdata;
					soc_pkg::CONTROL: control <= i_request.wdata;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (select)
			soc_pkg::COUNTER: read_data = counter;
			soc_pkg::COMPARE: read_data = compare;
			soc_pkg::CONTROL: read_data = control;
			default: read_data = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_valid)
			o_rdata <= read_data;
	end

	// Level interrupt while enabled and the count has reached compare
	assign o_interrupt = control[0] && (counter >= compare);

endmodule

// File: source/system_registers.sv
`include "soc_params.svh"

module system_registers(
	input i_clock,
	input i_reset,
	input i_valid,
	input soc_pkg::far_request_t i_request,
	output logic o_ready,
	output logic [`SOC_DATA_W-1:0] o_rdata,
	output logic [`SOC_LED_W-1:0] o_leds
);

	soc_pkg::sysreg_reg_e select;
	logic [`SOC_DATA_W-1:0] read_data;

	assign select = soc_pkg::sysreg_reg_e'(i_request.address[3:2]);

	// Only the LED register is writable
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_leds <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= i_valid;
			if (i_valid && i_request.rw && select == soc_pkg::LEDS)
				o_leds <= i_request.wdata[`SOC_LED_W-1:0];
		end
	end

	always_comb begin
		case (select)
			soc_pkg::DEVICE_ID: read_data = `SOC_DEVICE_ID;
			soc_pkg::FREQUENCY: read_data = `SOC_FREQUENCY;
			soc_pkg::LEDS: read_data = `SOC_DATA_W'(o_leds);
			default: read_data = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_valid)
			o_rdata <= read_data;
	end

endmodule

// File: source/soc_top.sv
`include "soc_params.svh"

module soc_top(
	input i_clock,
	input i_reset,

	input i_ibus_valid,
	input [`SOC_ADDR_W-1:0] i_ibus_address,
	output logic o_ibus_ready,
	output logic [`SOC_DATA_W-1:0] o_ibus_rdata,

	input i_dbus_valid,
	input soc_pkg::bus_request_t i_dbus_request,
	output logic o_dbus_ready,
	output logic [`SOC_DATA_W-1:0] o_dbus_rdata,

	input i_dma_valid,
	input soc_pkg::bus_request_t i_dma_request,
	output logic o_dma_ready,
	output logic [`SOC_DATA_W-1:0] o_dma_rdata,

	output logic [`SOC_LED_W-1:0] o_leds,
	output logic o_timer_interrupt,
	output logic o_bus_fault,
	output logic [`SOC_ADDR_W-1:0] o_fault_address,
	output soc_pkg::bus_source_e o_fault_source
);

	// ==============================
	// System bus
	// ==============================
	soc_pkg::bus_request_t target_request;
	logic rom_valid;
	logic ram_valid;
	logic bridge_valid;
	logic rom_ready;
	logic ram_ready;
	logic bridge_ready;
	logic [`SOC_DATA_W-1:0] rom_rdata;
	logic [`SOC_DATA_W-1:0] ram_rdata;
	logic [`SOC_DATA_W-1:0] bridge_rdata;

	system_bus bus(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_ibus_valid(i_ibus_valid),
		.i_ibus_address(i_ibus_address),
		.o_ibus_ready(o_ibus_ready),
		.o_ibus_rdata(o_ibus_rdata),
		.i_dbus_valid(i_dbus_valid),
		.i_dbus_request(i_dbus_request),
		.o_dbus_ready(o_dbus_ready),
		.o_dbus_rdata(o_dbus_rdata),
		.i_dma_valid(i_dma_valid),
		.i_dma_request(i_dma_request),
		.o_dma_ready(o_dma_ready),
		.o_dma_rdata(o_dma_rdata),
		.o_rom_valid(rom_valid),
		.o_ram_valid(ram_valid),
		.o_bridge_valid(bridge_valid),
		.o_target_request(target_request),
		.i_rom_ready(rom_ready),
		.i_rom_rdata(rom_rdata),
		.i_ram_ready(ram_ready),
		.i_ram_rdata(ram_rdata),
		.i_bridge_ready(bridge_ready),
		.i_bridge_rdata(bridge_rdata),
		.o_bus_fault(o_bus_fault),
		.o_fault_address(o_fault_address),
		.o_fault_source(o_fault_source)
	);

	boot_rom rom(
		.i_clock(i_clock),
		.i_valid(rom_valid),
		.i_address(target_request.address),
		.o_ready(rom_ready),
		.o_rdata(rom_rdata)
	);

	block_ram ram(
		.i_clock(i_clock),
		.i_valid(ram_valid),
		.i_request(target_request),
		.o_ready(ram_ready),
		.o_rdata(ram_rdata)
	);

	// ==============================
	// Bridge and far peripherals
	// ==============================
	soc_pkg::far_request_t far_request;
	logic timer_valid;
	logic sysreg_valid;
	logic timer_ready;
	logic sysreg_ready;
	logic [`SOC_DATA_W-1:0] timer_rdata;
	logic [`SOC_DATA_W-1:0] sysreg_rdata;

	io_bridge bridge(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(bridge_valid),
		.i_request(target_request),
		.o_ready(bridge_ready),
		.o_rdata(bridge_rdata),
		.o_timer_valid(timer_valid),
		.o_sysreg_valid(sysreg_valid),
		.o_far_request(far_request),
		.i_timer_ready(timer_ready),
		.i_timer_rdata(timer_rdata),
		.i_sysreg_ready(sysreg_ready),
		.i_sysreg_rdata(sysreg_rdata)
	);

	system_timer timer(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(timer_valid),
		.i_request(far_request),
		.o_ready(timer_ready),
		.o_rdata(timer_rdata),
		.o_interrupt(o_timer_interrupt)
	);

	system_registers sysreg(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(sysreg_valid),
		.i_request(far_request),
		.o_ready(sysreg_ready),
		.o_rdata(sysreg_rdata),
		.o_leds(o_leds)
	);

endmodule

// File: testbench/tb_clock.sv
module tb_clock(
	output logic o_clock
);

	// Period of 10 time units
	initial o_clock = 1'b0;

	always #5 o_clock = ~o_clock;

endmodule

// File: testbench/soc_assertions.sv
`include "soc_params.svh"

module soc_assertions(
	input i_clock,
	input i_reset,
	input i_ibus_valid,
	input [`SOC_ADDR_W-1:0] i_ibus_address,
	input i_ibus_ready,
	input i_dbus_valid,
	input soc_pkg::bus_request_t i_dbus_request,
	input i_dbus_ready,
	input i_dma_valid,
	input soc_pkg::bus_request_t i_dma_request,
	input i_dma_ready,
	input i_rom_ready,
	input i_ram_ready,
	input i_bridge_ready,
	input i_bus_fault,
	input [`SOC_ADDR_W-1:0] i_fault_address,
	input soc_pkg::bus_source_e i_owner
);

	// ==============================
	// Response routing
	// ==============================

	// One transfer on the bus, so one completion per cycle
	assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0({i_rom_ready, i_ram_ready, i_bridge_ready, i_bus_fault}))
		else $error("more than one completion in one cycle");

	// Ready only to the owner while it still requests
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_ibus_ready |-> (i_ibus_valid && i_owner == soc_pkg::INSTRUCTION))
		else $error("instruction ready without a granted request");

	assert property (@(posedge i_clock) disable iff (i_reset)
		i_dbus_ready |-> (i_dbus_valid && i_owner == soc_pkg::DATA))
		else $error("data ready without a granted request");

	assert property (@(posedge i_clock) disable iff (i_reset)
		i_dma_ready |-> (i_dma_valid && i_owner == soc_pkg::DMA))
		else $error("DMA ready without a granted request");

	// Fault only outside the mapped regions
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_fault |-> (i_fault_address[31:28] != `SOC_REGION_ROM
			&& i_fault_address[31:28] != `SOC_REGION_RAM
			&& i_fault_address[31:28] != `SOC_REGION_BRIDGE))
		else $error("bus fault on a mapped region");

	// ==============================
	// Master side handshake
	// ==============================
	assert property (@(posedge i_clock) disable iff (i_reset)
		(i_ibus_valid && !i_ibus_ready) |=> (i_ibus_valid && $stable(i_ibus_address)))
		else $error("instruction request changed before ready");

	assert property (@(posedge i_clock) disable iff (i_reset)
		(i_dbus_valid && !i_dbus_ready) |=> (i_dbus_valid && $stable(i_dbus_request)))
		else $error("data request changed before ready");

	assert property (@(posedge i_clock) disable iff (i_reset)
		(i_dma_valid && !i_dma_ready) |=> (i_dma_valid && $stable(i_dma_request)))
		else $error("DMA request changed before ready");

endmodule

bind system_bus soc_assertions i_soc_assertions(
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_ibus_valid(i_ibus_valid),
	.i_ibus_address(i_ibus_address),
	.i_ibus_ready(o_ibus_ready),
	.i_dbus_valid(i_dbus_valid),
	.i_dbus_request(i_dbus_request),
	.i_dbus_ready(o_dbus_ready),
	.i_dma_valid(i_dma_valid),
	.i_dma_request(i_dma_request),
	.i_dma_ready(o_dma_ready),
	.i_rom_ready(i_rom_ready),
	.i_ram_ready(i_ram_ready),
	.i_bridge_ready(i_bridge_ready),
	.i_bus_fault(o_bus_fault),
	.i_fault_address(o_fault_address),
	.i_owner(owner)
);

// File: testbench/tb_soc_top.sv
`include "soc_params.svh"

module tb_soc_top;

	localparam int RESET_CYCLES = 16;
	localparam int FILL_WORDS = 64;
	localparam int RAM_OPS = 80;
	localparam int ROM_OPS = 24;
	localparam int ROUNDS = 8;
	localparam int BRIDGE_OPS = 12;
	localparam int TIMER_OPS = 8;
	localparam int FAULT_OPS = 3;
	localparam int MAX_COMPARE = 127;
	localparam int TRANSACTIONS = FILL_WORDS + RAM_OPS + ROM_OPS + 2 + ROUNDS * 3
		+ BRIDGE_OPS + TIMER_OPS + FAULT_OPS;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TRANSACTIONS * 20 + MAX_COMPARE + 20;

	localparam logic [31:0] TIMER_BASE = {`SOC_REGION_BRIDGE, `SOC_FAR_TIMER, 24'h0};
	localparam logic [31:0] SYSREG_BASE = {`SOC_REGION_BRIDGE, `SOC_FAR_SYSREG, 24'h0};
	localparam logic [31:0] UNUSED_FAR = {`SOC_REGION_BRIDGE, 4'h3, 24'h10};

	logic clock;
	logic reset;
	logic ibus_valid;
	logic [31:0] ibus_address;
	logic ibus_ready;
	logic [31:0] ibus_rdata;
	logic dbus_valid;
	soc_pkg::bus_request_t dbus_request;
	logic dbus_ready;
	logic [31:0] dbus_rdata;
	logic dma_valid;
	soc_pkg::bus_request_t dma_request;
	logic dma_ready;
	logic [31:0] dma_rdata;
	logic [`SOC_LED_W-1:0] leds;
	logic timer_interrupt;
	logic bus_fault;
	logic [31:0] fault_address;
	soc_pkg::bus_source_e fault_source;

	integer seed = 32'h6fdb7457;
	int unsigned cycle = 0;
	int errors = 0;
	int checks = 0;
	int test_start_errors = 0;
	int fault_count = 0;

	// Fault report seen with the last ready
	logic last_fault;
	logic [31:0] last_fault_address;
	soc_pkg::bus_source_e last_fault_source;

	// Reference memory
	logic [31:0] ram_model [`SOC_RAM_WORDS];

	tb_clock clock_gen(
		.o_clock(clock)
	);

	soc_top i_soc_top(
		.i_clock(clock),
		.i_reset(reset),
		.i_ibus_valid(ibus_valid),
		.i_ibus_address(ibus_address),
		.o_ibus_ready(ibus_ready),
		.o_ibus_rdata(ibus_rdata),
		.i_dbus_valid(dbus_valid),
		.i_dbus_request(dbus_request),
		.o_dbus_ready(dbus_ready),
		.o_dbus_rdata(dbus_rdata),
		.i_dma_valid(dma_valid),
		.i_dma_request(dma_request),
		.o_dma_ready(dma_ready),
		.o_dma_rdata(dma_rdata),
		.o_leds(leds),
		.o_timer_interrupt(timer_interrupt),
		.o_bus_fault(bus_fault),
		.o_fault_address(fault_address),
		.o_fault_source(fault_source)
	);

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	always @(negedge clock) begin
		if (bus_fault)
			fault_count <= fault_count + 1;
	end

	// ==============================
	// Watchdog
	// ==============================
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Error: the run timed out after %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ==============================
	// Checks and reference model
	// ==============================
	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished, %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// Signature in the upper half, word index below
	function automatic logic [31:0] rom_expected(input logic [31:0] address);
		return {`SOC_ROM_SIGNATURE, 8'h00, address[9:2]};
	endfunction

	// Returns the stored word, then applies a write
	function automatic logic [31:0] ram_update(input logic rw, input logic [31:0] address,
		input logic [31:0] wdata);
		logic [31:0] old_word;
		old_word = ram_model[address[11:2]];
		if (rw)
			ram_model[address[11:2]] = wdata;
		return old_word;
	endfunction

	// 64 word window, random alias bits above bit 11
	function automatic logic [31:0] ram_address();
		logic [31:0] r;
		r = $random(seed);
		return {`SOC_REGION_RAM, r[27:12], 4'd0, r[5:0], 2'b00};
	endfunction

	function automatic logic [31:0] rom_address();
		logic [31:0] r;
		r = $random(seed);
		return {`SOC_REGION_ROM, r[27:2], 2'b00};
	endfunction

	function automatic soc_pkg::bus_source_e pick_port();
		logic [31:0] r;
		r = $random(seed);
		return r[0] ? soc_pkg::DMA : soc_pkg::DATA;
	endfunction

	// One transfer on one master port, up to its ready pulse
	task automatic bus_access(input soc_pkg::bus_source_e port, input logic rw,
		input logic [31:0] address, input logic [31:0] wdata,
		output logic [31:0] rdata, output int unsigned ready_cycle);
		logic ready;
		@(posedge clock);
		case (port)
			soc_pkg::INSTRUCTION: begin
				ibus_valid <= 1'b1;
				ibus_address <= address;
			end
			soc_pkg::DATA: begin
				dbus_valid <= 1'b1;
				dbus_request <= '{rw: rw, address: address, wdata: wdata};
			end
			default: begin
				dma_valid <= 1'b1;
				dma_request <= '{rw: rw, address: address, wdata: wdata};
			end
		endcase
		ready = 1'b0;
		rdata = '0;
		while (!ready) begin
			@(negedge clock);
			case (port)
				soc_pkg::INSTRUCTION: begin
					ready = ibus_ready;
					rdata = ibus_rdata;
				end
				soc_pkg::DATA: begin
					ready = dbus_ready;
					rdata = dbus_rdata;
				end
				default: begin
					ready = dma_ready;
					rdata = dma_rdata;
				end
			endcase
		end
		ready_cycle = cycle;
		last_fault = bus_fault;
		last_fault_address = fault_address;
		last_fault_source = fault_source;
		@(posedge clock);
		case (port)
			soc_pkg::INSTRUCTION: ibus_valid <= 1'b0;
			soc_pkg::DATA: dbus_valid <= 1'b0;
			default: dma_valid <= 1'b0;
		endcase
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		logic [31:0] address;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [31:0] expected;
		logic [31:0] compare;
		logic [31:0] i_address;
		logic [31:0] d_address;
		logic [31:0] m_address;
		logic [31:0] d_wdata;
		logic [31:0] m_wdata;
		logic [31:0] i_rdata;
		logic [31:0] d_rdata;
		logic [31:0] m_rdata;
		logic [31:0] d_expected;
		logic [31:0] m_expected;
		logic [2:0] mask;
		logic rw;
		logic d_rw;
		logic m_rw;
		logic seen;
		soc_pkg::bus_source_e port;
		int unsigned ready_cycle;
		int unsigned i_cycle;
		int unsigned d_cycle;
		int unsigned m_cycle;

		reset <= 1'b1;
		ibus_valid <= 1'b0;
		ibus_address <= '0;
		dbus_valid <= 1'b0;
		dbus_request <= '0;
		dma_valid <= 1'b0;
		dma_request <= '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("ready after reset", 32'({ibus_ready, dbus_ready, dma_ready}), 32'd0);
		check_value("fault after reset", 32'(bus_fault), 32'd0);
		check_value("interrupt after reset", 32'(timer_interrupt), 32'd0);
		check_value("leds after reset", 32'(leds), 32'd0);
		end_test("reset");

		// RAM window fill, old contents unknown
		for (int i = 0; i < FILL_WORDS; i++) begin
			address = {`SOC_REGION_RAM, 16'h0, 4'd0, 6'(i), 2'b00};
			wdata = {address[15:0], ~address[31:16]} ^ {16'(i * 7), 16'(i * 13)};
			expected = ram_update(1'b1, address, wdata);
			bus_access(soc_pkg::DATA, 1'b1, address, wdata, rdata, ready_cycle);
		end
		for (int i = 0; i < RAM_OPS; i++) begin
			port = pick_port();
			address = ram_address();
			wdata = $random(seed);
			rdata = $random(seed);
			rw = rdata[0];
			expected = ram_update(rw, address, wdata);
			bus_access(port, rw, address, wdata, rdata, ready_cycle);
			check_value(rw ? "RAM old word on write" : "RAM read", rdata, expected);
		end
		end_test("ram");

		for (int i = 0; i < ROM_OPS; i++) begin
			port = (i % 2 == 0) ? soc_pkg::INSTRUCTION : soc_pkg::DATA;
			address = rom_address();
			bus_access(port, 1'b0, address, 32'd0, rdata, ready_cycle);
			check_value("ROM read", rdata, rom_expected(address));
		end
		address = rom_address();
		wdata = $random(seed);
		bus_access(soc_pkg::DATA, 1'b1, address, wdata, rdata, ready_cycle);
		bus_access(soc_pkg::DATA, 1'b0, address, 32'd0, rdata, ready_cycle);
		check_value("ROM read after write", rdata, rom_expected(address));
		end_test("rom");

		// Simultaneous requests, model updated in grant order
		for (int r = 0; r < ROUNDS; r++) begin
			mask = 3'($random(seed));
			if ($countones(mask) < 2)
				mask = 3'b111;
			i_address = rom_address();
			d_address = ram_address();
			m_address = ram_address();
			d_wdata = $random(seed);
			m_wdata = $random(seed);
			rdata = $random(seed);
			d_rw = rdata[0];
			m_rw = rdata[1];
			d_expected = mask[1] ? ram_update(d_rw, d_address, d_wdata) : 32'd0;
			m_expected = mask[2] ? ram_update(m_rw, m_address, m_wdata) : 32'd0;
			fork
				if (mask[0])
					bus_access(soc_pkg::INSTRUCTION, 1'b0, i_address, 32'd0, i_rdata, i_cycle);
				if (mask[1])
					bus_access(soc_pkg::DATA, d_rw, d_address, d_wdata, d_rdata, d_cycle);
				if (mask[2])
					bus_access(soc_pkg::DMA, m_rw, m_address, m_wdata, m_rdata, m_cycle);
			join
			if (mask[0])
				check_value("concurrent instruction data", i_rdata, rom_expected(i_address));
			if (mask[1])
				check_value("concurrent data port data", d_rdata, d_expected);
			if (mask[2])
				check_value("concurrent DMA data", m_rdata, m_expected);
			if (mask[0] && mask[1])
				check_value("instruction before data", 32'(i_cycle < d_cycle), 32'd1);
			if (mask[1] && mask[2])
				check_value("data before DMA", 32'(d_cycle < m_cycle), 32'd1);
			if (mask[0] && mask[2])
				check_value("instruction before DMA", 32'(i_cycle < m_cycle), 32'd1);
		end
		end_test("arbitration");

		// ==============================
		// Bridge and far peripherals
		// ==============================
		for (int pass = 0; pass < 2; pass++) begin
			bus_access(pick_port(), 1'b0, SYSREG_BASE, 32'd0, rdata, ready_cycle);
			check_value("device ID", rdata, `SOC_DEVICE_ID);
			bus_access(pick_port(), 1'b0, SYSREG_BASE + 32'd4, 32'd0, rdata, ready_cycle);
			check_value("clock frequency", rdata, `SOC_FREQUENCY);
			if (pass == 0) begin
				bus_access(pick_port(), 1'b1, SYSREG_BASE, $random(seed), rdata, ready_cycle);
				bus_access(pick_port(), 1'b1, SYSREG_BASE + 32'd4, $random(seed), rdata,
					ready_cycle);
			end
		end
		for (int i = 0; i < 2; i++) begin
			wdata = $random(seed);
			bus_access(pick_port(), 1'b1, SYSREG_BASE + 32'd8, wdata, rdata, ready_cycle);
			check_value("LED outputs", 32'(leds), 32'(wdata[`SOC_LED_W-1:0]));
			bus_access(pick_port(), 1'b0, SYSREG_BASE + 32'd8, 32'd0, rdata, ready_cycle);
			check_value("LED read back", rdata, 32'(wdata[`SOC_LED_W-1:0]));
		end
		bus_access(pick_port(), 1'b0, UNUSED_FAR, 32'd0, rdata, ready_cycle);
		check_value("unused far device", rdata, 32'd0);
		end_test("bridge");

		rdata = $random(seed);
		compare = 32'd64 + (rdata & 32'd63);
		bus_access(soc_pkg::DATA, 1'b1, TIMER_BASE + 32'd4, compare, rdata, ready_cycle);
		bus_access(soc_pkg::DATA, 1'b1, TIMER_BASE, 32'd0, rdata, ready_cycle);
		bus_access(soc_pkg::DATA, 1'b1, TIMER_BASE + 32'd8, 32'd1, rdata, ready_cycle);
		check_value("interrupt before compare", 32'(timer_interrupt), 32'd0);
		seen = 1'b0;
		for (int i = 0; i < compare + 20 && !seen; i++) begin
			@(negedge clock);
			seen = timer_interrupt;
		end
		check_value("interrupt within compare bound", 32'(seen), 32'd1);
		bus_access(soc_pkg::DATA, 1'b0, TIMER_BASE + 32'd8, 32'd0, rdata, ready_cycle);
		check_value("timer control read back", rdata, 32'd1);
		bus_access(soc_pkg::DATA, 1'b0, TIMER_BASE + 32'd4, 32'd0, rdata, ready_cycle);
		check_value("timer compare read back", rdata, compare);
		bus_access(soc_pkg::DATA, 1'b1, TIMER_BASE + 32'd8, 32'd0, rdata, ready_cycle);
		check_value("interrupt after disable", 32'(timer_interrupt), 32'd0);
		bus_access(soc_pkg::DATA, 1'b0, TIMER_BASE + 32'd8, 32'd0, rdata, ready_cycle);
		check_value("timer control cleared", rdata, 32'd0);
		end_test("timer");

		// Unmapped regions, one per master
		for (int i = 1; i <= FAULT_OPS; i++) begin
			port = soc_pkg::bus_source_e'(2'(i));
			address = $random(seed);
			while (address[31:28] == `SOC_REGION_ROM || address[31:28] == `SOC_REGION_RAM
				|| address[31:28] == `SOC_REGION_BRIDGE)
				address = $random(seed);
			wdata = $random(seed);
			bus_access(port, wdata[0], address, wdata, rdata, ready_cycle);
			check_value("fault read data", rdata, 32'd0);
			check_value("fault pulse", 32'(last_fault), 32'd1);
			check_value("fault address", last_fault_address, address);
			check_value("fault source", 32'(last_fault_source), 32'(port));
		end
		@(negedge clock);
		check_value("fault pulse count", 32'(fault_count), 32'(FAULT_OPS));
		end_test("fault");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+source
source/soc_pkg.sv
source/system_bus.sv
source/boot_rom.sv
source/block_ram.sv
source/io_bridge.sv
source/system_timer.sv
source/system_registers.sv
source/soc_top.sv
testbench/tb_clock.sv
testbench/soc_assertions.sv
testbench/tb_soc_top.sv

// File: Makefile
TOP = tb_soc_top
LOG = sim.log

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f build.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q -e "SOME TESTS FAILED" -e "timed out" $(LOG); then \
		echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
